// ==== design/dma_pkg.sv ====
//########################################
// DMA front end package
// Request and status types, default geometry
//########################################
`default_nettype none

package dma_pkg;

  // Address and length widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] len_t;

  // Default cluster geometry
  localparam int unsigned NumGroupsDefault        = 4;
  // Must be a power of two
  localparam int unsigned GroupRegionBytesDefault = 64;
  localparam addr_t       TCDMBaseAddrDefault     = 32'h0000_0000;
  localparam int unsigned TCDMSizeDefault         = 4096;
  localparam int unsigned TransFifoDepthDefault   = 4;

  // One bit per group
  typedef logic [NumGroupsDefault-1:0] group_mask_t;

  // DMA transfer request
  typedef struct packed {
    addr_t src;
    addr_t dst;
    len_t  num_bytes;
  } dma_req_t;

  // Backend status, bit 0 is the idle level
  typedef struct packed {
    logic trans_complete;
    logic backend_idle;
  } dma_meta_t;

  // Status of an idle backend
  localparam dma_meta_t MetaIdle = '{trans_complete: 1'b0, backend_idle: 1'b1};

  // Split midend FSM
  typedef enum logic {
    IDLE,
    SPLITTING
  } split_state_e;

endpackage : dma_pkg

`default_nettype wire

// ==== design/dma_req_register.sv ====
//########################################
// DMA request cut
// Two-entry spill register on valid/ready
//########################################
`default_nettype none

module dma_req_register
  import dma_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  dma_req_t data_i,
  input  logic     valid_i,
  output logic     ready_o,
  output dma_req_t data_o,
  output logic     valid_o,
  input  logic     ready_i
);

  dma_req_t a_data_q;
  dma_req_t b_data_q;
  logic     a_full_q;
  logic     b_full_q;
  logic     a_fill;
  logic     a_drain;
  logic     b_fill;
  logic     b_drain;

  // A takes new data, B catches it when the output stalls
  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // B holds the older entry
  assign valid_o = a_full_q || b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;
  assign ready_o = !a_full_q || !b_full_q;

  // Stalled output holds its request
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule : dma_req_register

`default_nettype wire

// ==== design/dma_split_midend.sv ====
//########################################
// DMA split midend
// Cuts transfers at interleaving rows and
// merges their chunk completions
//########################################
`default_nettype none

module dma_split_midend
  import dma_pkg::*;
#(
  parameter int unsigned NumGroups        = NumGroupsDefault,
  parameter int unsigned GroupRegionBytes = GroupRegionBytesDefault,
  parameter addr_t       TCDMBaseAddr     = TCDMBaseAddrDefault,
  parameter int unsigned TCDMSize         = TCDMSizeDefault,
  parameter int unsigned TransFifoDepth   = TransFifoDepthDefault
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  dma_req_t  burst_req_i,
  input  logic      valid_i,
  output logic      ready_o,
  output dma_meta_t meta_o,
  output dma_req_t  burst_req_o,
  output logic      valid_o,
  input  logic      ready_i,
  input  dma_meta_t meta_i
);

  localparam int unsigned RowBytes    = NumGroups * GroupRegionBytes;
  localparam int unsigned RowW        = $clog2(RowBytes);
  localparam int unsigned PtrW        = (TransFifoDepth > 1) ? $clog2(TransFifoDepth) : 1;
  localparam int unsigned FillW       = PtrW + 1;
  localparam addr_t       TCDMEndAddr = TCDMBaseAddr + addr_t'(TCDMSize);

  split_state_e state_q;
  dma_req_t     cur_q;
  len_t         chunk_cnt_q;
  addr_t        rel_dst;
  logic         in_window;
  len_t         row_room;
  len_t         chunk_len;
  logic         last_chunk;
  logic         chunk_hs;
  logic         accept;

  // Chunk count per transfer, oldest first
  len_t             cnt_fifo_q [TransFifoDepth];
  logic [PtrW-1:0]  wr_ptr_q;
  logic [PtrW-1:0]  rd_ptr_q;
  logic [FillW-1:0] fill_q;
  len_t             done_cnt_q;
  logic             push;
  logic             pop;

  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(TransFifoDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign rel_dst    = cur_q.dst - TCDMBaseAddr;
  assign in_window  = (cur_q.dst >= TCDMBaseAddr) && (cur_q.dst < TCDMEndAddr);
  assign row_room   = len_t'(RowBytes) - len_t'(rel_dst[RowW-1:0]);
  assign chunk_len  = (in_window && cur_q.num_bytes > row_room) ? row_room : cur_q.num_bytes;
  assign last_chunk = chunk_len == cur_q.num_bytes;

  assign valid_o  = state_q == SPLITTING;
  assign chunk_hs = valid_o && ready_i;
  assign push     = chunk_hs && last_chunk;

  always_comb begin
    burst_req_o           = cur_q;
    burst_req_o.num_bytes = chunk_len;
  end

  // Next transfer enters together with the last chunk
  assign ready_o = (state_q == IDLE) ? (fill_q < FillW'(TransFifoDepth)) :
                   (push && fill_q < FillW'(TransFifoDepth - 1));
  assign accept  = valid_i && ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= IDLE;
      chunk_cnt_q <= '0;
    end else if (accept) begin
      state_q     <= SPLITTING;
      chunk_cnt_q <= '0;
    end else if (push) begin
      state_q <= IDLE;
    end else if (chunk_hs) begin
      chunk_cnt_q <= chunk_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      cur_q <= burst_req_i;
    end else if (chunk_hs) begin
      cur_q.src       <= cur_q.src + chunk_len;
      cur_q.dst       <= cur_q.dst + chunk_len;
      cur_q.num_bytes <= cur_q.num_bytes - chunk_len;
    end
    if (push) begin
      cnt_fifo_q[wr_ptr_q] <= chunk_cnt_q + 1'b1;
    end
  end

  // Chunks complete in order, so one counter serves the oldest transfer
  assign pop = (fill_q != '0) && (done_cnt_q == cnt_fifo_q[rd_ptr_q]);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fill_q     <= '0;
      done_cnt_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      fill_q     <= fill_q + FillW'(push) - FillW'(pop);
      done_cnt_q <= (pop ? '0 : done_cnt_q) + len_t'(meta_i.trans_complete);
    end
  end

  assign meta_o.trans_complete = pop;
  assign meta_o.backend_idle   = meta_i.backend_idle && (state_q == IDLE) && (fill_q == '0);

  // First and last byte of an in-window chunk share one row
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    chunk_hs && in_window && (burst_req_o.num_bytes != '0) |->
      ((rel_dst + burst_req_o.num_bytes - addr_t'(1)) >> RowW) == (rel_dst >> RowW));

endmodule : dma_split_midend

`default_nettype wire

// ==== design/dma_distributed_midend.sv ====
//########################################
// DMA distributed midend
// Scatters row chunks to the groups and
// merges the group completions
//########################################
`default_nettype none

module dma_distributed_midend
  import dma_pkg::*;
#(
  parameter int unsigned NumGroups        = NumGroupsDefault,
  parameter int unsigned GroupRegionBytes = GroupRegionBytesDefault,
  parameter addr_t       TCDMBaseAddr     = TCDMBaseAddrDefault,
  parameter int unsigned TCDMSize         = TCDMSizeDefault,
  parameter int unsigned TransFifoDepth   = TransFifoDepthDefault
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  dma_req_t                  burst_req_i,
  input  logic                      valid_i,
  output logic                      ready_o,
  output dma_meta_t                 meta_o,
  output dma_req_t  [NumGroups-1:0] burst_req_o,
  output group_mask_t               valid_o,
  input  group_mask_t               ready_i,
  input  dma_meta_t [NumGroups-1:0] meta_i
);

  localparam int unsigned RowBytes    = NumGroups * GroupRegionBytes;
  localparam int unsigned RowW        = $clog2(RowBytes);
  localparam int unsigned PtrW        = (TransFifoDepth > 1) ? $clog2(TransFifoDepth) : 1;
  localparam int unsigned FillW       = PtrW + 1;
  localparam int unsigned CntW        = $clog2(TransFifoDepth + 1);
  localparam addr_t       TCDMEndAddr = TCDMBaseAddr + addr_t'(TCDMSize);

  addr_t                     rel_dst;
  logic                      in_window;
  len_t                      row_off;
  len_t                      row_end;
  dma_req_t  [NumGroups-1:0] piece;
  group_mask_t               need;
  group_mask_t               slot_free;
  logic                      accept;
  dma_req_t  [NumGroups-1:0] slot_q;
  group_mask_t               slot_valid_q;

  // Group mask per chunk, oldest first
  group_mask_t      mask_fifo_q [TransFifoDepth];
  logic [PtrW-1:0]  wr_ptr_q;
  logic [PtrW-1:0]  rd_ptr_q;
  logic [FillW-1:0] fill_q;
  logic [CntW-1:0]  done_cnt_q [NumGroups];
  group_mask_t      has_done;
  group_mask_t      owe;
  logic             all_idle;
  logic             push;
  logic             pop;

  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(TransFifoDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign rel_dst   = burst_req_i.dst - TCDMBaseAddr;
  assign in_window = (burst_req_i.dst >= TCDMBaseAddr) && (burst_req_i.dst < TCDMEndAddr);
  assign row_off   = len_t'(rel_dst[RowW-1:0]);
  assign row_end   = row_off + burst_req_i.num_bytes;

  // Overlap of the chunk with each group slice of the row
  always_comb begin
    len_t slice_lo;
    len_t slice_hi;
    len_t lo;
    len_t hi;
    need = '0;
    for (int unsigned g = 0; g < NumGroups; g++) begin
      slice_lo           = len_t'(g * GroupRegionBytes);
      slice_hi           = slice_lo + len_t'(GroupRegionBytes);
      lo                 = (row_off > slice_lo) ? row_off : slice_lo;
      hi                 = (row_end < slice_hi) ? row_end : slice_hi;
      piece[g].src       = burst_req_i.src + (lo - row_off);
      piece[g].dst       = burst_req_i.dst + (lo - row_off);
      piece[g].num_bytes = hi - lo;
      need[g]            = in_window && (lo < hi);
    end
    // Outside the window group 0 takes it whole
    if (!in_window) begin
      piece[0] = burst_req_i;
      need[0]  = 1'b1;
    end
  end

  // A slot draining this cycle counts as free
  assign slot_free = ~slot_valid_q | ready_i;
  assign ready_o   = ((need & ~slot_free) == '0) && (fill_q < FillW'(TransFifoDepth));
  assign accept    = valid_i && ready_o;
  assign push      = accept;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      slot_valid_q <= '0;
    end else begin
      for (int unsigned g = 0; g < NumGroups; g++) begin
        if (accept && need[g]) begin
          slot_valid_q[g] <= 1'b1;
        end else if (ready_i[g]) begin
          slot_valid_q[g] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int unsigned g = 0; g < NumGroups; g++) begin
      if (accept && need[g]) begin
        slot_q[g] <= piece[g];
      end
    end
    if (push) begin
      mask_fifo_q[wr_ptr_q] <= need;
    end
  end

  assign valid_o     = slot_valid_q;
  assign burst_req_o = slot_q;

  // Groups may run ahead, so completions are counted per group
  always_comb begin
    has_done = '0;
    all_idle = 1'b1;
    for (int unsigned g = 0; g < NumGroups; g++) begin
      has_done[g] = done_cnt_q[g] != '0;
      all_idle    = all_idle && meta_i[g].backend_idle;
    end
  end

  assign owe = mask_fifo_q[rd_ptr_q] & ~has_done;
  assign pop = (fill_q != '0) && (owe == '0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
      for (int unsigned g = 0; g < NumGroups; g++) begin
        done_cnt_q[g] <= '0;
      end
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      fill_q <= fill_q + FillW'(push) - FillW'(pop);
      for (int unsigned g = 0; g < NumGroups; g++) begin
        done_cnt_q[g] <= done_cnt_q[g] + CntW'(meta_i[g].trans_complete)
                         - CntW'(pop && mask_fifo_q[rd_ptr_q][g]);
      end
    end
  end

  assign meta_o.trans_complete = pop;
  assign meta_o.backend_idle   = all_idle && (fill_q == '0) && (slot_valid_q == '0);

  // Early completions per group never overflow their counter
  for (genvar g = 0; g < NumGroups; g++) begin : gen_cnt_check
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      meta_i[g].trans_complete && !(pop && mask_fifo_q[rd_ptr_q][g]) |->
        done_cnt_q[g] != '1);
  end

endmodule : dma_distributed_midend

`default_nettype wire

// ==== design/dma_frontend.sv ====
//########################################
// DMA front end top
// Cut, split and distribute DMA requests
//########################################
`default_nettype none

module dma_frontend
  import dma_pkg::*;
#(
  parameter int unsigned NumGroups        = NumGroupsDefault,
  parameter int unsigned GroupRegionBytes = GroupRegionBytesDefault,
  parameter addr_t       TCDMBaseAddr     = TCDMBaseAddrDefault,
  parameter int unsigned TCDMSize         = TCDMSizeDefault,
  parameter int unsigned TransFifoDepth   = TransFifoDepthDefault
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // DMA request
  input  dma_req_t                  dma_req_i,
  input  logic                      dma_req_valid_i,
  output logic                      dma_req_ready_o,
  // DMA status
  output dma_meta_t                 dma_meta_o,
  // Group backends
  output dma_req_t  [NumGroups-1:0] grp_req_o,
  output group_mask_t               grp_valid_o,
  input  group_mask_t               grp_ready_i,
  input  dma_meta_t [NumGroups-1:0] grp_meta_i
);

  dma_req_t                  cut_req;
  logic                      cut_valid;
  logic                      cut_ready;
  dma_req_t                  split_req;
  logic                      split_valid;
  logic                      split_ready;
  dma_meta_t                 split_meta;
  dma_meta_t                 dist_meta;
  dma_meta_t [NumGroups-1:0] grp_meta_q;

  dma_req_register i_dma_req_register (
    .clk_i  (clk_i          ),
    .rst_n_i(rst_n_i        ),
    .data_i (dma_req_i      ),
    .valid_i(dma_req_valid_i),
    .ready_o(dma_req_ready_o),
    .data_o (cut_req        ),
    .valid_o(cut_valid      ),
    .ready_i(cut_ready      )
  );

  dma_split_midend #(
    .NumGroups       (NumGroups       ),
    .GroupRegionBytes(GroupRegionBytes),
    .TCDMBaseAddr    (TCDMBaseAddr    ),
    .TCDMSize        (TCDMSize        ),
    .TransFifoDepth  (TransFifoDepth  )
  ) i_dma_split_midend (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .burst_req_i(cut_req    ),
    .valid_i    (cut_valid  ),
    .ready_o    (cut_ready  ),
    .meta_o     (split_meta ),
    .burst_req_o(split_req  ),
    .valid_o    (split_valid),
    .ready_i    (split_ready),
    .meta_i     (dist_meta  )
  );

  dma_distributed_midend #(
    .NumGroups       (NumGroups       ),
    .GroupRegionBytes(GroupRegionBytes),
    .TCDMBaseAddr    (TCDMBaseAddr    ),
    .TCDMSize        (TCDMSize        ),
    .TransFifoDepth  (TransFifoDepth  )
  ) i_dma_distributed_midend (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .burst_req_i(split_req  ),
    .valid_i    (split_valid),
    .ready_o    (split_ready),
    .meta_o     (dist_meta  ),
    .burst_req_o(grp_req_o  ),
    .valid_o    (grp_valid_o),
    .ready_i    (grp_ready_i),
    .meta_i     (grp_meta_q )
  );

  // Status registered on the way in and out
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      grp_meta_q <= {NumGroups{MetaIdle}};
      dma_meta_o <= MetaIdle;
    end else begin
      grp_meta_q <= grp_meta_i;
      dma_meta_o <= split_meta;
    end
  end

endmodule : dma_frontend

`default_nettype wire

// ==== verification/tb_dma_frontend.sv ====
//########################################
// DMA front end testbench
// Group backend models and stimulus from file
//########################################
`default_nettype none

module tb_dma_frontend
  import dma_pkg::*;
();

  localparam int unsigned NumGroups = NumGroupsDefault;
  localparam int          MemWords  = 256;
  localparam string       InputFile = "verification/dma_frontend_input.txt";

  logic                      clk_i;
  logic                      rst_n_i = 1'b0;
  dma_req_t                  dma_req_i = '0;
  logic                      dma_req_valid_i = 1'b0;
  logic                      dma_req_ready_o;
  dma_meta_t                 dma_meta_o;
  dma_req_t  [NumGroups-1:0] grp_req_o;
  group_mask_t               grp_valid_o;
  group_mask_t               grp_ready_i = '0;
  dma_meta_t [NumGroups-1:0] grp_meta_i = {NumGroups{MetaIdle}};

  integer      seed = 5835;
  logic [31:0] words [MemWords];
  int          n_trans = 0;
  int          cpl_cnt = 0;
  dma_req_t    reqs [$];
  int          n_pieces [$];
  int          pieces_done [$];
  // Expected pieces per group with their transfer index
  dma_req_t    exp_q [NumGroups][$];
  int          exp_id_q [NumGroups][$];
  int          cpl_id_q [NumGroups][$];
  group_mask_t grp_fire = '0;
  logic [2:0]  cpl_pipe [NumGroups] = '{default: '0};
  int          busy_cnt [NumGroups] = '{default: 0};
  logic [1:0]  busy_hist = '0;

  dma_frontend u_dma_frontend (
    .clk_i          (clk_i          ),
    .rst_n_i        (rst_n_i        ),
    .dma_req_i      (dma_req_i      ),
    .dma_req_valid_i(dma_req_valid_i),
    .dma_req_ready_o(dma_req_ready_o),
    .dma_meta_o     (dma_meta_o     ),
    .grp_req_o      (grp_req_o      ),
    .grp_valid_o    (grp_valid_o    ),
    .grp_ready_i    (grp_ready_i    ),
    .grp_meta_i     (grp_meta_i     )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic stop_with_failure();
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_req(input string name, input dma_req_t exp, input dma_req_t act);
    if (exp !== act) begin
      $display("error %s: expected src %h dst %h len %h, actual src %h dst %h len %h",
               name, exp.src, exp.dst, exp.num_bytes, act.src, act.dst, act.num_bytes);
      stop_with_failure();
    end
  endtask

  task automatic check_meta(input string name, input dma_meta_t exp, input dma_meta_t act);
    if (exp !== act) begin
      $display("error %s: expected %b, actual %b", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_mask(input string name, input group_mask_t exp, input group_mask_t act);
    if (exp !== act) begin
      $display("error %s: expected %b, actual %b", name, exp, act);
      stop_with_failure();
    end
  endtask

  // Group backends take pieces under random ready and finish 3 cycles later
  always @(posedge clk_i) begin : group_models
    int id;
    if (rst_n_i) begin
      for (int g = 0; g < NumGroups; g++) begin
        grp_ready_i[g]               <= 1'($random(seed));
        grp_meta_i[g].trans_complete <= cpl_pipe[g][2];
        if (cpl_pipe[g][2]) begin
          id              = cpl_id_q[g].pop_front();
          pieces_done[id] = pieces_done[id] + 1;
        end
        busy_cnt[g] = busy_cnt[g] + int'(grp_fire[g]) - int'(cpl_pipe[g][2]);
        grp_meta_i[g].backend_idle <= (busy_cnt[g] == 0);
        cpl_pipe[g] <= {cpl_pipe[g][1:0], grp_fire[g]};
      end
    end
  end

  // Outputs are stable at the falling edge
  always @(negedge clk_i) begin : monitors
    dma_req_t exp;
    int       id;
    logic     any_busy;
    if (rst_n_i) begin
      any_busy = 1'b0;
      for (int g = 0; g < NumGroups; g++) begin
        any_busy    = any_busy || !grp_meta_i[g].backend_idle;
        grp_fire[g] = grp_valid_o[g] && grp_ready_i[g];
        if (grp_fire[g]) begin
          if (exp_q[g].size() == 0) begin
            $display("group %0d received a piece that no transfer expects", g);
            stop_with_failure();
          end
          exp = exp_q[g].pop_front();
          id  = exp_id_q[g].pop_front();
          check_req($sformatf("transfer %0d piece at group %0d", id, g), exp, grp_req_o[g]);
          cpl_id_q[g].push_back(id);
        end
      end
      if (dma_meta_o.trans_complete) begin
        if (cpl_cnt >= n_trans) begin
          $display("completion pulse with no transfer left to complete");
          stop_with_failure();
        end
        if (pieces_done[cpl_cnt] != n_pieces[cpl_cnt]) begin
          $display("transfer %0d completed before all of its pieces", cpl_cnt);
          stop_with_failure();
        end
        cpl_cnt = cpl_cnt + 1;
      end
      // Group status reaches dma_meta_o two cycles later
      if (busy_hist[1] && dma_meta_o.backend_idle) begin
        $display("backend_idle was high while a group backend was busy");
        stop_with_failure();
      end
      busy_hist = {busy_hist[0], any_busy};
    end
  end

  initial begin : main
    int   pos;
    int   g;
    len_t byte_sum;
    $readmemh(InputFile, words);
    n_trans = int'(words[0]);
    if (n_trans <= 0) begin
      $display("input file holds no transfers");
      stop_with_failure();
    end
    pos = 1;
    for (int t = 0; t < n_trans; t++) begin
      reqs.push_back('{src: words[pos], dst: words[pos+1], num_bytes: words[pos+2]});
      n_pieces.push_back(int'(words[pos+3]));
      pieces_done.push_back(0);
      pos      = pos + 4;
      byte_sum = '0;
      for (int p = 0; p < n_pieces[t]; p++) begin
        g = int'(words[pos]);
        exp_q[g].push_back('{src: words[pos+1], dst: words[pos+2], num_bytes: words[pos+3]});
        exp_id_q[g].push_back(t);
        byte_sum = byte_sum + words[pos+3];
        pos      = pos + 4;
      end
      if (byte_sum != reqs[t].num_bytes) begin
        $display("piece lengths of transfer %0d do not add up to its length", t);
        stop_with_failure();
      end
    end

    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_mask("reset group valid", '0, grp_valid_o);
    check_meta("reset status", MetaIdle, dma_meta_o);

    @(posedge clk_i);
    for (int t = 0; t < n_trans; t++) begin
      dma_req_i       <= reqs[t];
      dma_req_valid_i <= 1'b1;
      do @(negedge clk_i); while (!dma_req_ready_o);
      @(posedge clk_i);
    end
    dma_req_valid_i <= 1'b0;

    wait (cpl_cnt == n_trans);
    @(negedge clk_i);
    while (!dma_meta_o.backend_idle) @(negedge clk_i);
    check_meta("final status", MetaIdle, dma_meta_o);
    check_mask("final group valid", '0, grp_valid_o);
    for (int k = 0; k < NumGroups; k++) begin
      if (exp_q[k].size() != 0) begin
        $display("%0d pieces never arrived at group %0d", exp_q[k].size(), k);
        stop_with_failure();
      end
    end
    $display("Regression passed");
    $finish;
  end

  initial begin : watchdog
    wait (n_trans != 0);
    repeat (5 + 200 * n_trans) @(posedge clk_i);
    $display("timeout: the transfers did not finish within %0d cycles", 5 + 200 * n_trans);
    stop_with_failure();
  end

endmodule : tb_dma_frontend

`default_nettype wire

// ==== verification/dma_frontend_input.txt ====
// DMA front end stimulus in hex, first word is the number of transfers
// Transfer line: src dst num_bytes piece_count
// Piece lines after it: group src dst num_bytes, in arrival order per group
6
// Single piece inside the slice of group 2
80000000 00000090 00000010 1
2 80000000 00000090 00000010
// Crosses two row boundaries and every slice
80001000 000000e0 00000140 6
3 80001000 000000e0 00000020
0 80001020 00000100 00000040
1 80001060 00000140 00000040
2 800010a0 00000180 00000040
3 800010e0 000001c0 00000040
0 80001120 00000200 00000020
// Destination outside the TCDM window
00000040 10000000 00000300 1
0 00000040 10000000 00000300
// Partial slices inside one row
90000000 00000234 00000050 3
0 90000000 00000234 0000000c
1 9000000c 00000240 00000040
2 9000004c 00000280 00000004
// Last slice of one row into the next row
a0000000 000003c0 00000080 2
3 a0000000 000003c0 00000040
0 a0000040 00000400 00000040
// Two full rows
b0000000 00000500 00000200 8
0 b0000000 00000500 00000040
1 b0000040 00000540 00000040
2 b0000080 00000580 00000040
3 b00000c0 000005c0 00000040
0 b0000100 00000600 00000040
1 b0000140 00000640 00000040
2 b0000180 00000680 00000040
3 b00001c0 000006c0 00000040

// ==== src.f ====
design/dma_pkg.sv
design/dma_req_register.sv
design/dma_split_midend.sv
design/dma_distributed_midend.sv
design/dma_frontend.sv
verification/tb_dma_frontend.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_dma_frontend
RTL_TOP    := dma_frontend
FILELIST   := src.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
FAIL_MSG   := Regression failed
PASS_MSG   := Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
